/* hw/arbiter_pkg.sv */
package arbiter_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;
  localparam int unsigned ROW_W  = 64;

  // scratchpad tile geometry with strides in bytes
  localparam int unsigned TILE_ROWS   = 4;
  localparam int unsigned ROW_STRIDE  = 8;
  localparam int unsigned WORD_STRIDE = 4;

  // ram model
  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned RAM_LATENCY = 2;

  // derived widths
  localparam int unsigned ROW_IDX_W  = $clog2(TILE_ROWS);
  localparam int unsigned MEM_IDX_W  = $clog2(MEM_WORDS);
  localparam int unsigned BYTE_OFF_W = $clog2(WORD_STRIDE);
  localparam int unsigned LAT_CNT_W  = $clog2(RAM_LATENCY + 1);

  // status reported by the ram on every cycle
  typedef enum logic {
    BUSY   = 1'b0,
    ACCESS = 1'b1
  } ramstate_t;

endpackage

/* hw/ram_model.sv */
`timescale 1ns/10ps

module ram_model (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic [arbiter_pkg::ADDR_W-1:0] ramaddr,
  input  logic [arbiter_pkg::WORD_W-1:0] ramstore,
  input  logic                           ramREN,
  input  logic                           ramWEN,
  output logic [arbiter_pkg::WORD_W-1:0] ramload,
  output arbiter_pkg::ramstate_t         ramstate
);
  import arbiter_pkg::*;

  // word storage
  logic [WORD_W-1:0] mem [MEM_WORDS];

  logic                 req;
  logic [LAT_CNT_W-1:0] lat_cnt;
  logic [MEM_IDX_W-1:0] word_idx;

  assign req = ramREN | ramWEN;

  // upper address bits beyond the array depth are ignored
  assign word_idx = ramaddr[BYTE_OFF_W +: MEM_IDX_W];

  // access once the countdown has run its full latency
  always_comb begin
    if (req && (lat_cnt == LAT_CNT_W'(RAM_LATENCY))) begin
      ramstate = ACCESS;
    end else begin
      ramstate = BUSY;
    end
  end

  // busy countdown
  // restarts after every access and when the request goes away
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end else if (!req || (ramstate == ACCESS)) begin
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  // write commits at the edge closing the access cycle
  always_ff @(posedge CLK) begin
    if (ramWEN && (ramstate == ACCESS)) begin
      mem[word_idx] <= ramstore;
    end
  end

  // combinational read path that is valid while ramstate is ACCESS
  assign ramload = mem[word_idx];

  // byte offset must be zero for any active request
  property p_word_aligned;
    @(posedge CLK) disable iff (!nRST)
      req |-> (ramaddr[BYTE_OFF_W-1:0] == '0);
  endproperty

  a_word_aligned: assert property (p_word_aligned)
    else $error("ram_model: unaligned address %h", ramaddr);

endmodule

/* hw/memory_arbiter.sv */
`timescale 1ns/10ps

module memory_arbiter (
  input  logic                               CLK,
  input  logic                               nRST,
  // data cache
  input  logic                               dREN,
  input  logic                               dWEN,
  input  logic [arbiter_pkg::ADDR_W-1:0]     daddr,
  input  logic [arbiter_pkg::WORD_W-1:0]     dstore,
  output logic [arbiter_pkg::WORD_W-1:0]     dload,
  output logic                               dwait,
  // instruction cache
  input  logic                               iREN,
  input  logic [arbiter_pkg::ADDR_W-1:0]     iaddr,
  output logic [arbiter_pkg::WORD_W-1:0]     iload,
  output logic                               iwait,
  // scratchpad load engine
  input  logic                               sLoad,
  input  logic [arbiter_pkg::ADDR_W-1:0]     load_addr,
  output logic [arbiter_pkg::ROW_W-1:0]      load_data,
  output logic [arbiter_pkg::ROW_IDX_W-1:0]  sLoad_row,
  output logic                               sLoad_hit,
  // scratchpad store engine
  input  logic                               sStore,
  input  logic [arbiter_pkg::ADDR_W-1:0]     store_addr,
  input  logic [arbiter_pkg::ROW_W-1:0]      store_data,
  output logic                               sStore_hit,
  // ram port
  output logic [arbiter_pkg::ADDR_W-1:0]     ramaddr,
  output logic [arbiter_pkg::WORD_W-1:0]     ramstore,
  output logic                               ramREN,
  output logic                               ramWEN,
  input  logic [arbiter_pkg::WORD_W-1:0]     ramload,
  input  arbiter_pkg::ramstate_t             ramstate
);
  import arbiter_pkg::*;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    SP_LOAD1  = 3'd1,
    SP_LOAD2  = 3'd2,
    SP_STORE1 = 3'd3,
    SP_STORE2 = 3'd4,
    DCACHE    = 3'd5,
    ICACHE    = 3'd6
  } arb_state_t;

  arb_state_t state, next_state;

  logic [ROW_IDX_W-1:0] row_cnt, next_row_cnt;
  logic [ROW_IDX_W-1:0] row_out;
  logic [ROW_W-1:0]     load_buf;
  logic [ADDR_W-1:0]    row_addr;
  logic                 ram_access;
  logic                 data_req;
  logic                 last_row;

  assign ram_access = (ramstate == ACCESS);
  assign data_req   = dREN | dWEN;
  assign last_row   = (row_cnt == ROW_IDX_W'(TILE_ROWS - 1));

  // start of the current tile row
  assign row_addr = load_addr + ADDR_W'(row_cnt) * ADDR_W'(ROW_STRIDE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      row_cnt <= '0;
    end else begin
      state   <= next_state;
      row_cnt <= next_row_cnt;
    end
  end

  // grant order is sp load, then sp store, dcache and icache
  always_comb begin
    next_state   = state;
    next_row_cnt = row_cnt;
    case (state)
      IDLE: begin
        if (sLoad) begin
          next_state   = SP_LOAD1;
          next_row_cnt = '0;
        end else if (sStore) begin
          next_state = SP_STORE1;
        end else if (data_req) begin
          next_state = DCACHE;
        end else if (iREN) begin
          next_state = ICACHE;
        end
      end
      SP_LOAD1: begin
        if (!sLoad) begin
          next_state = IDLE;
        end else if (ram_access) begin
          next_state = SP_LOAD2;
        end
      end
      SP_LOAD2: begin
        if (!sLoad) begin
          next_state = IDLE;
        end else if (ram_access) begin
          if (last_row) begin
            next_state   = IDLE;
            next_row_cnt = '0;
          end else begin
            next_state   = SP_LOAD1;
            next_row_cnt = row_cnt + 1'b1;
          end
        end
      end
      SP_STORE1: begin
        if (!sStore) begin
          next_state = IDLE;
        end else if (ram_access) begin
          next_state = SP_STORE2;
        end
      end
      SP_STORE2: begin
        if (!sStore || ram_access) begin
          next_state = IDLE;
        end
      end
      DCACHE: begin
        if (!data_req || ram_access) begin
          next_state = IDLE;
        end
      end
      ICACHE: begin
        // a data request cancels the fetch and wins the next grant
        if (!iREN || data_req || ram_access) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // ram port and client handshakes
  always_comb begin
    ramaddr    = '0;
    ramstore   = '0;
    ramREN     = 1'b0;
    ramWEN     = 1'b0;
    dwait      = 1'b1;
    dload      = '0;
    iwait      = 1'b1;
    iload      = '0;
    sStore_hit = 1'b0;
    case (state)
      SP_LOAD1: begin
        ramaddr = row_addr;
        ramREN  = sLoad;
      end
      SP_LOAD2: begin
        ramaddr = row_addr + ADDR_W'(WORD_STRIDE);
        ramREN  = sLoad;
      end
      SP_STORE1: begin
        ramaddr  = store_addr;
        ramstore = store_data[WORD_W-1:0];
        ramWEN   = sStore;
      end
      SP_STORE2: begin
        ramaddr    = store_addr + ADDR_W'(WORD_STRIDE);
        ramstore   = store_data[ROW_W-1:WORD_W];
        ramWEN     = sStore;
        sStore_hit = ram_access;
      end
      DCACHE: begin
        ramaddr  = daddr;
        ramstore = dstore;
        // write wins over read
        ramWEN   = dWEN;
        ramREN   = dREN & ~dWEN;
        dwait    = ~ram_access;
        dload    = ramload;
      end
      ICACHE: begin
        ramaddr = iaddr;
        ramREN  = iREN & ~data_req;
        iwait   = ~ram_access;
        iload   = ramload;
      end
      default: begin
      end
    endcase
  end

  // row buffer fills the low word first then the high word
  always_ff @(posedge CLK) begin
    if ((state == SP_LOAD1) && ram_access) begin
      load_buf[WORD_W-1:0] <= ramload;
    end else if ((state == SP_LOAD2) && ram_access) begin
      load_buf[ROW_W-1:WORD_W] <= ramload;
    end
  end

  // hit one cycle after the second word of a row
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sLoad_hit <= 1'b0;
      row_out   <= '0;
    end else begin
      sLoad_hit <= (state == SP_LOAD2) && ram_access;
      if ((state == SP_LOAD2) && ram_access) begin
        row_out <= row_cnt;
      end
    end
  end

  assign load_data = load_buf;
  assign sLoad_row = row_out;

  a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramREN && ramWEN))
    else $error("memory_arbiter: read and write requested together");

  a_hit_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    sLoad_hit |=> !sLoad_hit)
    else $error("memory_arbiter: sLoad_hit held for two cycles");

  // a dcache completion needs an ACCESS for a request placed on the ram port
  a_dwait_access: assert property (@(posedge CLK) disable iff (!nRST)
    !dwait |-> ((ramstate == ACCESS) && (ramREN || ramWEN)))
    else $error("memory_arbiter: dwait low without ram access");

endmodule

/* hw/memory_subsystem.sv */
`timescale 1ns/10ps

module memory_subsystem (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              dREN,
  input  logic                              dWEN,
  input  logic [arbiter_pkg::ADDR_W-1:0]    daddr,
  input  logic [arbiter_pkg::WORD_W-1:0]    dstore,
  output logic [arbiter_pkg::WORD_W-1:0]    dload,
  output logic                              dwait,
  input  logic                              iREN,
  input  logic [arbiter_pkg::ADDR_W-1:0]    iaddr,
  output logic [arbiter_pkg::WORD_W-1:0]    iload,
  output logic                              iwait,
  input  logic                              sLoad,
  input  logic [arbiter_pkg::ADDR_W-1:0]    load_addr,
  output logic [arbiter_pkg::ROW_W-1:0]     load_data,
  output logic [arbiter_pkg::ROW_IDX_W-1:0] sLoad_row,
  output logic                              sLoad_hit,
  input  logic                              sStore,
  input  logic [arbiter_pkg::ADDR_W-1:0]    store_addr,
  input  logic [arbiter_pkg::ROW_W-1:0]     store_data,
  output logic                              sStore_hit
);
  import arbiter_pkg::*;

  // arbiter to ram
  logic [ADDR_W-1:0] ramaddr;
  logic [WORD_W-1:0] ramstore;
  logic              ramREN;
  logic              ramWEN;
  // ram to arbiter
  logic [WORD_W-1:0] ramload;
  ramstate_t         ramstate;

  memory_arbiter arb_i (.*);

  ram_model ram_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // reset held for 10 cycles, released on a falling edge
  initial begin
    nRST = 1'b0;
    repeat (10) @(negedge CLK);
    nRST <= 1'b1;
  end

endmodule

/* verif/memory_subsystem_tb.sv */
`timescale 1ns/10ps

module memory_subsystem_tb;
  import arbiter_pkg::*;

  logic                 CLK;
  logic                 nRST;
  logic                 dREN;
  logic                 dWEN;
  logic [ADDR_W-1:0]    daddr;
  logic [WORD_W-1:0]    dstore;
  logic [WORD_W-1:0]    dload;
  logic                 dwait;
  logic                 iREN;
  logic [ADDR_W-1:0]    iaddr;
  logic [WORD_W-1:0]    iload;
  logic                 iwait;
  logic                 sLoad;
  logic [ADDR_W-1:0]    load_addr;
  logic [ROW_W-1:0]     load_data;
  logic [ROW_IDX_W-1:0] sLoad_row;
  logic                 sLoad_hit;
  logic                 sStore;
  logic [ADDR_W-1:0]    store_addr;
  logic [ROW_W-1:0]     store_data;
  logic                 sStore_hit;

  // expected memory contents
  logic [WORD_W-1:0] shadow [MEM_WORDS];

  int unsigned tests = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  logic        aborted = 1'b0;

  tb_clock_gen clk_i (
    .CLK  (CLK),
    .nRST (nRST)
  );

  memory_subsystem memory_subsystem_i (.*);

  // word index from the byte address with the upper bits wrapping
  function automatic logic [MEM_IDX_W-1:0] word_index(input logic [ADDR_W-1:0] addr);
    return addr[BYTE_OFF_W +: MEM_IDX_W];
  endfunction

  // every address bit feeds the pattern
  function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  task automatic compare_word(input string name, input logic [WORD_W-1:0] expected,
                              input logic [WORD_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_row(input string name, input logic [ROW_W-1:0] expected,
                             input logic [ROW_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_row_index(input string name, input logic [ROW_IDX_W-1:0] expected,
                                   input logic [ROW_IDX_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic compare_state(input string name, input ramstate_t expected,
                               input ramstate_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at %0t: %s expected %s, got %s", $time, name, expected.name(),
               actual.name());
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("at %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what, input logic [ADDR_W-1:0] addr);
    errors++;
    aborted = 1'b1;
    $display("at %0t: %s at address %h got no response within 200 cycles", $time, what, addr);
  endtask

  task automatic dcache_access(input logic write, input logic [ADDR_W-1:0] addr,
                               input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
    int   cycles;
    int   low_cycles;
    logic done;
    cycles = 0;
    low_cycles = 0;
    done = 1'b0;
    rdata = '0;
    dWEN = write;
    dREN = !write;
    daddr = addr;
    dstore = wdata;
    while (!done && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (!dwait) begin
        done = 1'b1;
        low_cycles++;
        rdata = dload;
        compare_state("ramstate", ACCESS, memory_subsystem_i.ramstate);
      end
    end
    if (!done) begin
      dREN = 1'b0;
      dWEN = 1'b0;
      report_timeout("data cache access", addr);
    end else begin
      // held through the access cycle and released in the next
      @(negedge CLK);
      if (!dwait) begin
        low_cycles++;
      end
      dREN = 1'b0;
      dWEN = 1'b0;
      if (low_cycles != 1) begin
        report_problem($sformatf("dwait was low for %0d cycles at address %h", low_cycles, addr));
      end
    end
  endtask

  task automatic instr_fetch(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] rdata);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    rdata = '0;
    iREN = 1'b1;
    iaddr = addr;
    while (!done && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (!iwait) begin
        done = 1'b1;
        rdata = iload;
      end
    end
    if (!done) begin
      iREN = 1'b0;
      report_timeout("instruction fetch", addr);
    end else begin
      @(negedge CLK);
      iREN = 1'b0;
    end
  endtask

  task automatic check_load_row(input logic [ADDR_W-1:0] base, input int r);
    logic [ADDR_W-1:0] row_base;
    logic [ROW_W-1:0]  expected;
    row_base = base + ADDR_W'(r * ROW_STRIDE);
    expected = {shadow[word_index(row_base + ADDR_W'(WORD_STRIDE))], shadow[word_index(row_base)]};
    compare_row("load_data", expected, load_data);
    compare_row_index("sLoad_row", ROW_IDX_W'(r), sLoad_row);
  endtask

  task automatic scratch_store(input logic [ADDR_W-1:0] addr, input logic [ROW_W-1:0] row);
    int                cycles;
    int                hits;
    logic              done;
    logic [WORD_W-1:0] rd;
    cycles = 0;
    hits = 0;
    done = 1'b0;
    sStore = 1'b1;
    store_addr = addr;
    store_data = row;
    while (!done && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (sStore_hit) begin
        done = 1'b1;
        hits++;
      end
    end
    if (!done) begin
      sStore = 1'b0;
      report_timeout("scratchpad store", addr);
    end else begin
      @(negedge CLK);
      if (sStore_hit) begin
        hits++;
      end
      sStore = 1'b0;
      if (hits != 1) begin
        report_problem($sformatf("sStore_hit was seen %0d times at address %h", hits, addr));
      end
      shadow[word_index(addr)] = row[WORD_W-1:0];
      shadow[word_index(addr + ADDR_W'(WORD_STRIDE))] = row[ROW_W-1:WORD_W];
      // read the row back through the data cache
      dcache_access(1'b0, addr, '0, rd);
      compare_word("dload", shadow[word_index(addr)], rd);
      if (!aborted) begin
        dcache_access(1'b0, addr + ADDR_W'(WORD_STRIDE), '0, rd);
        compare_word("dload", shadow[word_index(addr + ADDR_W'(WORD_STRIDE))], rd);
      end
    end
  endtask

  task automatic scratch_load(input logic [ADDR_W-1:0] addr);
    int cycles;
    int r;
    cycles = 0;
    r = 0;
    sLoad = 1'b1;
    load_addr = addr;
    while (r < TILE_ROWS && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (sLoad_hit) begin
        check_load_row(addr, r);
        r++;
        cycles = 0;
      end
    end
    // dropped within the last hit cycle so no new load starts
    sLoad = 1'b0;
    if (r < TILE_ROWS) begin
      report_timeout("scratchpad load", addr);
    end
  endtask

  // load and data read raised together and the load must finish first
  task automatic load_vs_dcache(input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] addr);
    int   cycles;
    int   r;
    logic done;
    cycles = 0;
    r = 0;
    done = 1'b0;
    sLoad = 1'b1;
    load_addr = base;
    dREN = 1'b1;
    daddr = addr;
    while (!done && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (sLoad_hit && r < TILE_ROWS) begin
        check_load_row(base, r);
        r++;
        cycles = 0;
        if (r == TILE_ROWS) begin
          sLoad = 1'b0;
        end
      end
      if (!dwait) begin
        done = 1'b1;
        compare_word("dload", shadow[word_index(addr)], dload);
        if (r < TILE_ROWS) begin
          report_problem($sformatf("dwait fell after only %0d load hits", r));
        end
      end
    end
    sLoad = 1'b0;
    if (!done) begin
      dREN = 1'b0;
      report_timeout("data read behind scratchpad load", addr);
    end else begin
      @(negedge CLK);
      dREN = 1'b0;
    end
  endtask

  // data read raised while a fetch is under way
  task automatic fetch_vs_dcache(input logic [ADDR_W-1:0] ia, input logic [ADDR_W-1:0] da);
    logic [WORD_W-1:0] rd;
    int                cycles;
    logic              done;
    cycles = 0;
    done = 1'b0;
    iREN = 1'b1;
    iaddr = ia;
    @(negedge CLK);
    if (!iwait) begin
      report_problem("fetch finished before the data request was raised");
    end
    dREN = 1'b1;
    daddr = da;
    while (!done && cycles < 200) begin
      @(negedge CLK);
      cycles++;
      if (!iwait) begin
        report_problem("iwait fell while the data request was pending");
      end
      if (!dwait) begin
        done = 1'b1;
        compare_word("dload", shadow[word_index(da)], dload);
      end
    end
    if (!done) begin
      dREN = 1'b0;
      iREN = 1'b0;
      report_timeout("data read during fetch", da);
    end else begin
      @(negedge CLK);
      dREN = 1'b0;
      instr_fetch(ia, rd);
      compare_word("iload", shadow[word_index(ia)], rd);
    end
  endtask

  task automatic run_test(input string op, input logic [ADDR_W-1:0] addr,
                          input logic [31:0] aux, input logic [63:0] data,
                          input logic [63:0] expect_val);
    logic [WORD_W-1:0] rd;
    logic [ROW_W-1:0]  row;
    if (op == "DW") begin
      dcache_access(1'b1, addr, data[WORD_W-1:0], rd);
      shadow[word_index(addr)] = data[WORD_W-1:0];
    end else if (op == "DR") begin
      dcache_access(1'b0, addr, '0, rd);
      compare_word("dload", expect_val[WORD_W-1:0], rd);
    end else if (op == "IR") begin
      instr_fetch(addr, rd);
      compare_word("iload", expect_val[WORD_W-1:0], rd);
    end else if (op == "SS") begin
      row = data;
      if (aux[0]) begin
        row = {$urandom, $urandom};
      end
      scratch_store(addr, row);
    end else if (op == "SL") begin
      scratch_load(addr);
    end else if (op == "PRI") begin
      if (aux[0]) begin
        fetch_vs_dcache(addr, data[ADDR_W-1:0]);
      end else begin
        load_vs_dcache(addr, data[ADDR_W-1:0]);
      end
    end else begin
      report_problem($sformatf("unknown operation %s in the test file", op));
    end
  endtask

  initial begin
    string             line;
    string             op;
    int                fd;
    int                n;
    int                cycles;
    int unsigned       seed_val;
    int unsigned       err_before;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       aux;
    logic [63:0]       data;
    logic [63:0]       expect_val;
    logic [WORD_W-1:0] rd;
    dREN = 1'b0;
    dWEN = 1'b0;
    daddr = '0;
    dstore = '0;
    iREN = 1'b0;
    iaddr = '0;
    sLoad = 1'b0;
    load_addr = '0;
    sStore = 1'b0;
    store_addr = '0;
    store_data = '0;
    seed_val = $urandom(4545);
    cycles = 0;
    while (!nRST && cycles < 200) begin
      @(negedge CLK);
      cycles++;
    end
    if (!nRST) begin
      report_timeout("reset release", '0);
    end
    // whole array written once through the data cache
    err_before = errors;
    for (int i = 0; i < MEM_WORDS && !aborted; i++) begin
      addr = ADDR_W'(i * WORD_STRIDE);
      dcache_access(1'b1, addr, fill_word(addr), rd);
      shadow[i] = fill_word(addr);
    end
    tests++;
    $display("test %0d FILL %0d words: %s", tests, MEM_WORDS,
             (errors == err_before) ? "pass" : "fail");
    fd = 0;
    if (!aborted) begin
      fd = $fopen("verif/arbiter_tests.txt", "r");
      if (fd == 0) begin
        report_problem("could not open verif/arbiter_tests.txt");
      end
    end
    while (fd != 0 && !aborted && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h", op, addr, aux, data, expect_val);
        if (n != 5) begin
          report_problem($sformatf("malformed test line: %s", line));
        end else begin
          err_before = errors;
          run_test(op, addr, aux, data, expect_val);
          tests++;
          $display("test %0d %s %h: %s", tests, op, addr,
                   (errors == err_before) ? "pass" : "fail");
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* verif/arbiter_tests.txt */
# columns: op addr aux data expect, all hex; unused fields are 0
# SS aux 1 uses a random row; PRI aux 0 is load against dcache, aux 1 is fetch against dcache
DW 00000040 0 00000000deadbeef 0
DW 00000044 0 0000000012345678 0
DW 00000100 0 00000000cafef00d 0
DW 00000480 0 000000000badf00d 0
DR 00000040 0 0 deadbeef
DR 00000044 0 0 12345678
DR 00000100 0 0 cafef00d
DR 00000080 0 0 0badf00d
IR 00000044 0 0 12345678
IR 00000100 0 0 cafef00d
SS 00000200 0 0123456789abcdef 0
DR 00000200 0 0 89abcdef
DR 00000204 0 0 01234567
SS 00000058 1 0 0
SS 00000300 1 0 0
SL 00000040 0 0 0
SL 00000300 0 0 0
SL 000001f8 0 0 0
PRI 00000200 0 00000040 0
PRI 00000100 1 00000044 0
DW 000003fc 0 00000000feedface 0
IR 000003fc 0 0 feedface

/* verilog.f */
hw/arbiter_pkg.sv
hw/ram_model.sv
hw/memory_arbiter.sv
hw/memory_subsystem.sv
verif/tb_clock_gen.sv
verif/memory_subsystem_tb.sv

/* Bender.yml */
package:
  name: memory_subsystem

dependencies: {}

sources:
  # package first, then the RAM, the arbiter and the top level
  - files:
      - hw/arbiter_pkg.sv
      - hw/ram_model.sv
      - hw/memory_arbiter.sv
      - hw/memory_subsystem.sv

  # testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/memory_subsystem_tb.sv
